// ==== logic/mpuPkg.sv ====
`default_nettype none

`include "mpu_defines.svh"

package mpuPkg;

    // Decoded message, offset bits 34..31 dropped
    typedef struct packed {
        logic [`TAG_WIDTH-1:0]    tag;
        logic [`INDEX_WIDTH-1:0]  index;
        logic                     which;
        logic [`NEWVAL_WIDTH-1:0] newVal;
    } msgFieldsT;

    // One vertex as stored in memory, properties byte-reversed
    typedef struct packed {
        logic [`VPROP_WIDTH-1:0]    tempProp;
        logic [`VPROP_WIDTH-1:0]    prop;
        logic [`VPROP_WIDTH-1:0]    unused;
        logic [`EDGE_DEG_WIDTH-1:0] edgeDeg;
        logic                       spare;
        logic                       active;
    } vertexRecT;

    typedef union packed {
        logic [`DATA_WIDTH-1:0] raw;    // As a memory beat
        vertexRecT [1:0]        vtx;    // Vertex 0 in the low half
    } vertexPairU;

    typedef struct packed {
        logic                                            valid;
        logic [`LINE_WIDTH-`DATA_WIDTH-`TAG_WIDTH-2:0]   pad;
        logic [`TAG_WIDTH-1:0]                           tag;
        vertexPairU                                      data;
    } cacheLineT;

    // Execute to result writer
    typedef struct packed {
        msgFieldsT               msg;
        vertexPairU              base;      // Line before the update
        logic                    hit;
        logic [`VPROP_WIDTH-1:0] result;
        logic                    update;
        logic                    send;
    } updateJobT;

    typedef struct packed {
        logic [`TAG_WIDTH-1:0]                                    tag;
        logic [`INDEX_WIDTH-1:0]                                  index;
        logic                                                     which;
        logic [`VERTEX_ID_WIDTH-`TAG_WIDTH-`INDEX_WIDTH-2:0]      offset;
    } vertexIdT;

    // Memory keeps property bytes in the opposite order
    function automatic logic [`VPROP_WIDTH-1:0] byteSwap(input logic [`VPROP_WIDTH-1:0] value);
        byteSwap = {value[7:0], value[15:8], value[23:16], value[31:24]};
    endfunction

endpackage

`default_nettype wire

// ==== logic/mpuTop.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mpu_defines.svh"

module mpuTop
    import mpuPkg::*;
#(
    parameter logic [`PE_NUM_WIDTH-1:0] peNum = '0
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire [`MSG_WIDTH-1:0]    MsgData,
    input  wire                     MsgEmpty,
    input  wire cacheLineT          CacheReadData,
    input  wire [`DATA_WIDTH-1:0]   ReadData,
    input  wire                     ReadReady,
    input  wire                     AvFull,
    output logic                    MsgRead,
    output logic [`INDEX_WIDTH-1:0] CacheAddr,
    output logic                    CacheWriteEn,
    output cacheLineT               CacheWriteData,
    output logic                    StartRead,
    output logic [`ADDR_WIDTH-1:0]  ReadAddress,
    output logic                    AvWrite,
    output vertexIdT                AvData
);

    msgFieldsT msgFields;
    logic      msgValid;
    logic      busy;        // Execute holds off the next pop
    updateJobT job;
    logic      jobValid;
    logic      done;

    msgDecode decodeInst (
        .clk       (clk),
        .reset     (reset),
        .MsgData   (MsgData),
        .MsgEmpty  (MsgEmpty),
        .busy      (busy),
        .MsgRead   (MsgRead),
        .msgFields (msgFields),
        .msgValid  (msgValid)
    );

    vertexExecute #(
        .peNum (peNum)
    ) executeInst (
        .clk           (clk),
        .reset         (reset),
        .msgFields     (msgFields),
        .msgValid      (msgValid),
        .CacheReadData (CacheReadData),
        .ReadData      (ReadData),
        .ReadReady     (ReadReady),
        .done          (done),
        .CacheAddr     (CacheAddr),
        .StartRead     (StartRead),
        .ReadAddress   (ReadAddress),
        .busy          (busy),
        .job           (job),
        .jobValid      (jobValid)
    );

    resultWriter writerInst (
        .clk            (clk),
        .reset          (reset),
        .job            (job),
        .jobValid       (jobValid),
        .AvFull         (AvFull),
        .CacheWriteEn   (CacheWriteEn),
        .CacheWriteData (CacheWriteData),
        .AvWrite        (AvWrite),
        .AvData         (AvData),
        .done           (done)
    );

endmodule

`default_nettype wire

// ==== logic/mpu_defines.svh ====
`ifndef MPU_DEFINES_SVH
`define MPU_DEFINES_SVH

//======================================================================
// Message format
//======================================================================
`define MSG_WIDTH         64
`define MSG_TAG_LSB       46    // Tag in bits 63..46
`define MSG_INDEX_LSB     36    // Cache index in bits 45..36
`define MSG_WHICH_BIT     35    // Vertex select within the pair
`define NEWVAL_WIDTH      31

// Vertex record fields
`define VPROP_WIDTH       32
`define EDGE_DEG_WIDTH    30

//======================================================================
// Cache and memory
//======================================================================
`define CACHE_DEPTH       1024
`define TAG_WIDTH         18
`define INDEX_WIDTH       10
`define DATA_WIDTH        256   // One memory beat, one vertex pair
`define LINE_WIDTH        288

`define ADDR_WIDTH        33
`define PE_NUM_WIDTH      4
`define ADDR_TAG_WIDTH    13    // Low tag bits used in the address
`define ADDR_OFFSET_WIDTH 5     // 32-byte pair alignment

`define VERTEX_ID_WIDTH   33

`endif

// ==== logic/msgDecode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mpu_defines.svh"

module msgDecode
    import mpuPkg::*;
(
    input  wire                  clk,
    input  wire                  reset,
    input  wire [`MSG_WIDTH-1:0] MsgData,
    input  wire                  MsgEmpty,
    input  wire                  busy,
    output logic                 MsgRead,
    output msgFieldsT            msgFields,
    output logic                 msgValid
);

    typedef enum logic [1:0] {
        POP_IDLE,
        POP_READ,       // Read strobe to the FIFO
        POP_CAPTURE,    // FIFO word valid
        POP_VALID       // Fields handed to execute
    } popStateT;

    popStateT popState;

    //==================================================================
    // Pop state machine
    //==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            popState <= POP_IDLE;
        end else begin
            case (popState)
                POP_IDLE: begin
                    if (!MsgEmpty && !busy) begin
                        popState <= POP_READ;
                    end
                end
                POP_READ:    popState <= POP_CAPTURE;
                POP_CAPTURE: popState <= POP_VALID;
                default:     popState <= POP_IDLE;   // Busy is set by now
            endcase
        end
    end

    assign MsgRead  = (popState == POP_READ);
    assign msgValid = (popState == POP_VALID);

    // Split the returned word
    always_ff @(posedge clk) begin
        if (popState == POP_CAPTURE) begin
            msgFields.tag    <= MsgData[`MSG_TAG_LSB +: `TAG_WIDTH];
            msgFields.index  <= MsgData[`MSG_INDEX_LSB +: `INDEX_WIDTH];
            msgFields.which  <= MsgData[`MSG_WHICH_BIT];
            msgFields.newVal <= MsgData[`NEWVAL_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== logic/resultWriter.sv ====
`timescale 1ns/1ns
`default_nettype none

module resultWriter
    import mpuPkg::*;
(
    input  wire            clk,
    input  wire            reset,
    input  wire updateJobT job,
    input  wire            jobValid,
    input  wire            AvFull,
    output logic           CacheWriteEn,
    output cacheLineT      CacheWriteData,
    output logic           AvWrite,
    output vertexIdT       AvData,
    output logic           done
);

    logic       pending;     // Job accepted, write or push not yet issued
    logic       needWrite;
    logic       canIssue;
    vertexRecT  oldRec;
    vertexRecT  newRec;
    vertexPairU newData;

    //==================================================================
    // Issue control
    //==================================================================
    assign needWrite = !job.hit || job.update;    // Miss installs the fetched line
    assign canIssue  = pending && !AvFull;

    assign CacheWriteEn = canIssue && needWrite;
    assign AvWrite      = canIssue && job.send;   // Send implies a write
    assign done         = pending && (!needWrite || !AvFull);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (jobValid) begin
            pending <= 1'b1;
        end else if (done) begin
            pending <= 1'b0;
        end
    end

    //==================================================================
    // Line build
    //==================================================================
    always_comb begin
        oldRec          = job.base.vtx[job.msg.which];
        newRec          = oldRec;
        newRec.tempProp = byteSwap(job.result);
        newRec.prop     = byteSwap(job.result);
        newRec.active   = oldRec.active | job.send;
        newData         = job.base;
        if (job.update) begin
            newData.vtx[job.msg.which] = newRec;    // Other vertex untouched
        end
    end

    always_comb begin
        CacheWriteData.valid = 1'b1;
        CacheWriteData.pad   = '0;
        CacheWriteData.tag   = job.msg.tag;
        CacheWriteData.data  = newData;
    end

    // Active vertex id is the message address
    always_comb begin
        AvData.tag    = job.msg.tag;
        AvData.index  = job.msg.index;
        AvData.which  = job.msg.which;
        AvData.offset = '0;
    end

endmodule

`default_nettype wire

// ==== logic/vertexExecute.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mpu_defines.svh"

module vertexExecute
    import mpuPkg::*;
#(
    parameter logic [`PE_NUM_WIDTH-1:0] peNum = '0
) (
    input  wire                     clk,
    input  wire                     reset,
    input  wire msgFieldsT          msgFields,
    input  wire                     msgValid,
    input  wire cacheLineT          CacheReadData,
    input  wire [`DATA_WIDTH-1:0]   ReadData,
    input  wire                     ReadReady,
    input  wire                     done,
    output logic [`INDEX_WIDTH-1:0] CacheAddr,
    output logic                    StartRead,
    output logic [`ADDR_WIDTH-1:0]  ReadAddress,
    output logic                    busy,
    output updateJobT               job,
    output logic                    jobValid
);

    typedef enum logic [2:0] {
        EX_IDLE,
        EX_CACHE_WAIT,
        EX_HIT_TEST,
        EX_FETCH,
        EX_REDUCE
    } exStateT;

    exStateT                 exState;
    logic                    lineHit;
    vertexRecT               selRec;
    logic [`VPROP_WIDTH-1:0] tempProp;
    logic [`VPROP_WIDTH-1:0] prop;
    logic [`VPROP_WIDTH-1:0] newValExt;
    logic                    doUpdate;
    logic                    doSend;

    assign lineHit = CacheReadData.valid && (CacheReadData.tag == job.msg.tag);

    //==================================================================
    // Minimum reduction (BFS / SSSP)
    //==================================================================
    assign selRec    = job.base.vtx[job.msg.which];
    assign tempProp  = byteSwap(selRec.tempProp);
    assign prop      = byteSwap(selRec.prop);
    assign newValExt = {{(`VPROP_WIDTH-`NEWVAL_WIDTH){1'b0}}, job.msg.newVal};
    assign doUpdate  = newValExt < tempProp;
    assign doSend    = doUpdate && !selRec.active && (selRec.edgeDeg != '0);

    //==================================================================
    // Lookup state machine
    //==================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            exState <= EX_IDLE;
        end else begin
            case (exState)
                EX_IDLE: begin
                    if (msgValid) begin
                        exState <= EX_CACHE_WAIT;
                    end
                end
                EX_CACHE_WAIT: exState <= EX_HIT_TEST;    // Read data next cycle
                EX_HIT_TEST:   exState <= lineHit ? EX_REDUCE : EX_FETCH;
                EX_FETCH: begin
                    if (ReadReady) begin
                        exState <= EX_REDUCE;
                    end
                end
                default:       exState <= EX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            StartRead <= 1'b0;
            jobValid  <= 1'b0;
        end else begin
            StartRead <= (exState == EX_HIT_TEST) && !lineHit;
            jobValid  <= (exState == EX_REDUCE);
            if (msgValid) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // Job payload, held until the next message
    always_ff @(posedge clk) begin
        if (msgValid && exState == EX_IDLE) begin
            job.msg   <= msgFields;
            CacheAddr <= msgFields.index;
        end
        if (exState == EX_HIT_TEST) begin
            job.hit     <= lineHit;
            job.base    <= CacheReadData.data;    // Replaced on a miss
            ReadAddress <= {1'b0, peNum, job.msg.tag[`ADDR_TAG_WIDTH-1:0], job.msg.index,
                            {`ADDR_OFFSET_WIDTH{1'b0}}};
        end
        if (exState == EX_FETCH && ReadReady) begin
            job.base.raw <= ReadData;
        end
        if (exState == EX_REDUCE) begin
            job.update <= doUpdate;
            job.result <= doUpdate ? newValExt : prop;
            job.send   <= doSend;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+logic
logic/mpuPkg.sv
logic/msgDecode.sv
logic/vertexExecute.sv
logic/resultWriter.sv
logic/mpuTop.sv
verif/mpu_assert.sv
verif/mpuTb.sv

// ==== verif/mpuTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mpu_defines.svh"

module mpuTb
    import mpuPkg::*;
();

    localparam logic [`PE_NUM_WIDTH-1:0] tbPeNum = 4'd5;
    localparam int waitLimit = 200;

    typedef struct packed {
        logic      write;
        cacheLineT line;
        logic      push;
        vertexIdT  id;
    } expectT;

    logic                    clk;
    logic                    reset;
    logic [`MSG_WIDTH-1:0]   MsgData;
    logic                    MsgEmpty;
    cacheLineT               CacheReadData;
    logic [`DATA_WIDTH-1:0]  ReadData;
    logic                    ReadReady;
    logic                    AvFull;
    logic                    MsgRead;
    logic [`INDEX_WIDTH-1:0] CacheAddr;
    logic                    CacheWriteEn;
    cacheLineT               CacheWriteData;
    logic                    StartRead;
    logic [`ADDR_WIDTH-1:0]  ReadAddress;
    logic                    AvWrite;
    vertexIdT                AvData;

    cacheLineT               cacheMem [`CACHE_DEPTH];
    vertexPairU              memData [logic [`ADDR_WIDTH-1:0]];
    logic [`MSG_WIDTH-1:0]   msgQueue [$];
    cacheLineT               expLines [$];
    vertexIdT                expIds [$];
    logic [`ADDR_WIDTH-1:0]  expAddrs [$];
    logic [`ADDR_WIDTH-1:0]  fetchAddr;
    logic [`INDEX_WIDTH-1:0] expIndex = '0;
    logic [31:0]             lfsrState = 32'd18;
    int    fetchDelay = 0;
    int    mismatches = 0;
    int    otherErrors = 0;
    int    doneCount = 0;
    int    writeCount = 0;
    int    pushCount = 0;
    int    msgStart = 0;
    int    holdWrites = 0;
    int    holdPushes = 0;
    string testName = "reset";

    mpuTop #(
        .peNum (tbPeNum)
    ) UUT (
        .clk            (clk),
        .reset          (reset),
        .MsgData        (MsgData),
        .MsgEmpty       (MsgEmpty),
        .CacheReadData  (CacheReadData),
        .ReadData       (ReadData),
        .ReadReady      (ReadReady),
        .AvFull         (AvFull),
        .MsgRead        (MsgRead),
        .CacheAddr      (CacheAddr),
        .CacheWriteEn   (CacheWriteEn),
        .CacheWriteData (CacheWriteData),
        .StartRead      (StartRead),
        .ReadAddress    (ReadAddress),
        .AvWrite        (AvWrite),
        .AvData         (AvData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //======================================================================
    // Helpers and reference model
    //======================================================================
    function automatic logic [63:0] randBits(input int width);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value     = {value[62:0], lfsrState[0]};    // One step per bit
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'hD0000001 : lfsrState >> 1;
        end
        return value;
    endfunction

    function automatic logic [31:0] swapBytes(input logic [31:0] value);
        swapBytes = {<<8{value}};
    endfunction

    function automatic vertexRecT makeRec(input logic [31:0] temp, input logic [31:0] prop,
                                          input logic [29:0] deg, input logic active);
        vertexRecT rec;
        rec          = '0;
        rec.tempProp = swapBytes(temp);
        rec.prop     = swapBytes(prop);
        rec.edgeDeg  = deg;
        rec.active   = active;
        return rec;
    endfunction

    function automatic vertexPairU makePair(input vertexRecT v0, input vertexRecT v1);
        vertexPairU pair;
        pair.vtx[0] = v0;
        pair.vtx[1] = v1;
        return pair;
    endfunction

    function automatic vertexPairU randomPair();
        vertexPairU pair;
        for (int i = 0; i < 4; i++) begin
            pair.raw[i*64 +: 64] = randBits(64);
        end
        return pair;
    endfunction

    function automatic logic [`ADDR_WIDTH-1:0] fetchAddress(input logic [17:0] tag,
                                                            input logic [9:0] index);
        return {1'b0, tbPeNum, tag[12:0], index, 5'b0};
    endfunction

    // Minimum reduction on the selected vertex
    function automatic expectT reduceRef(input msgFieldsT msg, input logic hit,
                                         input vertexPairU base);
        expectT      exp;
        vertexRecT   rec;
        logic [31:0] temp;
        logic        update;
        rec       = base.vtx[msg.which];
        temp      = swapBytes(rec.tempProp);
        update    = {1'b0, msg.newVal} < temp;
        exp.push  = update && !rec.active && rec.edgeDeg != 0;
        exp.write = !hit || update;
        if (update) begin
            rec.tempProp        = swapBytes({1'b0, msg.newVal});
            rec.prop            = rec.tempProp;
            rec.active          = rec.active | exp.push;
            base.vtx[msg.which] = rec;
        end
        exp.line.valid = 1'b1;
        exp.line.pad   = '0;
        exp.line.tag   = msg.tag;
        exp.line.data  = base;
        exp.id.tag     = msg.tag;
        exp.id.index   = msg.index;
        exp.id.which   = msg.which;
        exp.id.offset  = '0;
        return exp;
    endfunction

    task automatic checkLine(input string name, input cacheLineT expected,
                             input cacheLineT actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s cache line: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkVertexId(input string name, input vertexIdT expected,
                                 input vertexIdT actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s vertex id: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkAddress(input string name, input logic [`ADDR_WIDTH-1:0] expected,
                                input logic [`ADDR_WIDTH-1:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s read address: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkIndex(input string name, input logic [`INDEX_WIDTH-1:0] expected,
                              input logic [`INDEX_WIDTH-1:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("MISMATCH %s cache index: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic endRun();
        int assertFails;
        assertFails = UUT.assertInst.failCount;
        $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, otherErrors, assertFails);
        if (mismatches + otherErrors + assertFails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic waitDone(input int startCount, input string what);
        int cycles;
        cycles = 0;
        while (doneCount == startCount && cycles < waitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (doneCount == startCount) begin
            otherErrors++;
            $display("Timeout: message of %s was never finished by the DUT", what);
            endRun();
        end
    endtask

    //======================================================================
    // FIFO, cache and memory models
    //======================================================================
    always @(posedge clk) begin
        if (MsgRead) begin
            if (msgQueue.size() == 0) begin
                otherErrors++;
                $display("Message FIFO was read while empty");
            end else begin
                MsgData <= msgQueue.pop_front();
            end
        end
        MsgEmpty <= (msgQueue.size() == 0);
    end

    always @(posedge clk) begin
        if (CacheWriteEn) begin
            cacheMem[CacheAddr] = CacheWriteData;
        end
        CacheReadData <= cacheMem[CacheAddr];    // One-cycle read
    end

    always @(posedge clk) begin
        ReadReady <= 1'b0;
        if (StartRead) begin
            if (expAddrs.size() == 0) begin
                otherErrors++;
                $display("Unexpected memory read at address %h", ReadAddress);
            end else begin
                checkAddress(testName, expAddrs.pop_front(), ReadAddress);
            end
            fetchAddr  = ReadAddress;
            fetchDelay = 1 + int'(randBits(2));
        end else if (fetchDelay > 0) begin
            fetchDelay--;
            if (fetchDelay == 0) begin
                ReadReady <= 1'b1;
                ReadData  <= memData.exists(fetchAddr) ? memData[fetchAddr].raw : '0;
            end
        end
    end

    // Compare every write and push against the expected queues
    always @(posedge clk) begin
        if (!reset) begin
            if (CacheWriteEn) begin
                writeCount++;
                if (expLines.size() == 0) begin
                    otherErrors++;
                    $display("%s: unexpected cache write at index %0d", testName, CacheAddr);
                end else begin
                    checkLine(testName, expLines.pop_front(), CacheWriteData);
                    checkIndex(testName, expIndex, CacheAddr);
                end
            end
            if (AvWrite) begin
                pushCount++;
                if (expIds.size() == 0) begin
                    otherErrors++;
                    $display("%s: unexpected active-vertex push of %h", testName, AvData);
                end else begin
                    checkVertexId(testName, expIds.pop_front(), AvData);
                end
            end
            if (UUT.done) begin
                doneCount++;
            end
        end
    end

    //======================================================================
    // Stimulus
    //======================================================================
    task automatic startMessage(input string name, input logic [17:0] tag,
                                input logic [9:0] index, input logic which,
                                input logic [30:0] newVal);
        msgFieldsT              msg;
        cacheLineT              line;
        vertexPairU             base;
        logic                   hit;
        logic [`ADDR_WIDTH-1:0] addr;
        expectT                 exp;
        msg.tag    = tag;
        msg.index  = index;
        msg.which  = which;
        msg.newVal = newVal;
        line       = cacheMem[index];
        hit        = (line.valid === 1'b1) && (line.tag === tag);
        if (hit) begin
            base = line.data;
        end else begin
            addr = fetchAddress(tag, index);
            if (!memData.exists(addr)) begin
                memData[addr] = randomPair();
            end
            base = memData[addr];
            expAddrs.push_back(addr);
        end
        exp = reduceRef(msg, hit, base);
        if (exp.write) begin
            expLines.push_back(exp.line);
        end
        if (exp.push) begin
            expIds.push_back(exp.id);
        end
        testName = name;
        expIndex = index;
        msgStart = doneCount;
        msgQueue.push_back({tag, index, which, 4'b0, newVal});
    endtask

    task automatic finishMessage();
        waitDone(msgStart, testName);
        if (expLines.size() != 0 || expIds.size() != 0 || expAddrs.size() != 0) begin
            otherErrors++;
            $display("%s: an expected cache write, push or memory read did not happen",
                     testName);
            expLines.delete();
            expIds.delete();
            expAddrs.delete();
        end
    endtask

    task automatic randomMessage();
        logic [63:0] pick;
        pick = randBits(35);
        startMessage("randomStream", {17'h0, pick[0]}, {8'h40, pick[2:1]}, pick[3], pick[34:4]);
        finishMessage();
    endtask

    initial begin
        reset         = 1'b1;
        MsgData       = '0;
        MsgEmpty      = 1'b1;
        CacheReadData = '0;
        ReadData      = '0;
        ReadReady     = 1'b0;
        AvFull        = 1'b0;
        for (int i = 0; i < `CACHE_DEPTH; i++) begin
            cacheMem[i] = '0;    // All lines invalid
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);

        // Miss installs the pair, then hits on it
        memData[fetchAddress(18'h2A5, 10'h011)] = makePair(makeRec(100, 100, 3, 1'b0),
                                                           makeRec(200, 200, 7, 1'b1));
        startMessage("missInstall", 18'h2A5, 10'h011, 1'b0, 31'd40);
        finishMessage();
        startMessage("hitSmaller", 18'h2A5, 10'h011, 1'b1, 31'd150);
        finishMessage();
        startMessage("hitNotSmaller", 18'h2A5, 10'h011, 1'b0, 31'd60);
        finishMessage();
        startMessage("hitAfterNoWrite", 18'h2A5, 10'h011, 1'b0, 31'd10);
        finishMessage();

        // Zero degree blocks the push, clear active flag allows it
        memData[fetchAddress(18'h00007, 10'h222)] = makePair(makeRec(500, 500, 0, 1'b0),
                                                             makeRec(9, 9, 4, 1'b0));
        startMessage("zeroDegree", 18'h00007, 10'h222, 1'b0, 31'd20);
        finishMessage();
        startMessage("hitPush", 18'h00007, 10'h222, 1'b1, 31'd3);
        finishMessage();

        // Back-pressure from a full active-vertex FIFO
        memData[fetchAddress(18'h3FFFF, 10'h3FF)] = makePair(makeRec(80, 80, 2, 1'b0),
                                                             makeRec(90, 90, 2, 1'b0));
        @(posedge clk);
        AvFull <= 1'b1;
        @(negedge clk);
        holdWrites = writeCount;
        holdPushes = pushCount;
        startMessage("avFullHold", 18'h3FFFF, 10'h3FF, 1'b1, 31'd12);
        repeat (20) @(negedge clk);
        if (writeCount != holdWrites || pushCount != holdPushes || doneCount != msgStart) begin
            otherErrors++;
            $display("avFullHold: write or push happened while AvFull was high");
        end
        @(posedge clk);
        AvFull <= 1'b0;
        finishMessage();

        for (int n = 0; n < 40; n++) begin
            randomMessage();
        end
        endRun();
    end

endmodule

`default_nettype wire

// ==== verif/mpu_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module mpuAssert (
    input wire clk,
    input wire reset,
    input wire MsgRead,
    input wire MsgEmpty,
    input wire StartRead,
    input wire CacheWriteEn,
    input wire AvWrite,
    input wire AvFull
);

    int failCount = 0;    // Read by the testbench at the end of the run

    popNotEmpty: assert property (@(posedge clk) disable iff (reset) MsgRead |-> !MsgEmpty)
        else begin
            failCount++;
            $error("MsgRead is high while the message FIFO is empty");
        end

    startReadPulse: assert property (@(posedge clk) disable iff (reset) StartRead |=> !StartRead)
        else begin
            failCount++;
            $error("StartRead stayed high for more than one cycle");
        end

    // Back-pressure from the active-vertex FIFO
    holdWhenFull: assert property (@(posedge clk) disable iff (reset)
                                   (CacheWriteEn || AvWrite) |-> !AvFull)
        else begin
            failCount++;
            $error("Cache write or active-vertex push while AvFull is high");
        end

endmodule

bind mpuTop mpuAssert assertInst (
    .clk          (clk),
    .reset        (reset),
    .MsgRead      (MsgRead),
    .MsgEmpty     (MsgEmpty),
    .StartRead    (StartRead),
    .CacheWriteEn (CacheWriteEn),
    .AvWrite      (AvWrite),
    .AvFull       (AvFull)
);

`default_nettype wire
